//--- source/board_pkg.sv
//******************************
// word-addressed bus with 32-bit data and 4 byte lanes
// one transaction in flight, no read-modify-write
// slave indices double as device table entry numbers
//******************************
package board_pkg;

	typedef logic [31:0] arch_word_t;
	// byte address without its two low bits
	typedef logic [29:0] word_addr_t;
	typedef logic [3:0]  byte_sel_t;
	typedef logic [1:0]  bus_op_t;

	localparam bus_op_t OP_NONE  = 2'd0;
	localparam bus_op_t OP_WRITE = 2'd1;
	localparam bus_op_t OP_READ  = 2'd2;

	typedef struct packed {
		bus_op_t    op;
		word_addr_t addr;
		arch_word_t data;
		byte_sel_t  sel;
	} bus_req_t;

	typedef struct packed {
		arch_word_t data;
		logic       rdy;
	} bus_rsp_t;

	typedef logic [1:0] slave_idx_t;

	// slaves sit one after another from word 0 in this order
	localparam slave_idx_t SLV_DEVTBL  = 2'd0;
	localparam slave_idx_t SLV_RAM     = 2'd1;
	localparam slave_idx_t SLV_INVALID = 2'd2;
	localparam int         SLAVE_COUNT = 3;

	localparam arch_word_t DEVTBL_ID  = 32'd7;
	localparam arch_word_t RAM_ID     = 32'd1;
	localparam arch_word_t INVALID_ID = 32'd0;

	localparam word_addr_t DEVTBL_MAPSZ   = 30'd64;
	localparam word_addr_t RSTCTRL_OFFSET = 30'd32;

	// 3 cold reset, 2 warm reset, 1 power-off
	typedef struct packed {
		logic rst1;
		logic rst0;
	} rst_ctrl_t;

	localparam int RST_CNTR_BITS = 4;

endpackage

//--- source/bus_decode.sv
//******************************
// one request at a time, rdy comes one cycle after accept
// RAM_WORDS must match the RAM slave and the device table
// unmapped words read zero and ignore writes
//******************************
`timescale 1ns/1ps

module bus_decode #(
	parameter int RAM_WORDS = 256
) (
	input  logic                clk120mhz,
	input  logic                sys_rst_i,
	input  board_pkg::bus_req_t bus_req_i,
	output board_pkg::bus_rsp_t bus_rsp_o,
	output board_pkg::bus_req_t slv_req_o,
	output logic                devtbl_sel_o,
	output logic                ram_sel_o,
	input  board_pkg::bus_rsp_t devtbl_rsp_i,
	input  board_pkg::bus_rsp_t ram_rsp_i
);

	localparam board_pkg::word_addr_t RAM_BASE = board_pkg::DEVTBL_MAPSZ;
	localparam board_pkg::word_addr_t INVALID_BASE =
		board_pkg::DEVTBL_MAPSZ + board_pkg::word_addr_t'(RAM_WORDS);

	typedef enum logic {
		ST_IDLE,
		ST_RSP
	} dec_state_t;

	dec_state_t            state_q;
	board_pkg::slave_idx_t slave_q;
	board_pkg::slave_idx_t tgt;
	board_pkg::word_addr_t offs;
	logic                  accept;

	// target slave and the offset inside it
	always_comb begin
		tgt  = board_pkg::SLV_INVALID;
		offs = bus_req_i.addr - INVALID_BASE;
		if (bus_req_i.addr < RAM_BASE) begin
			tgt  = board_pkg::SLV_DEVTBL;
			offs = bus_req_i.addr;
		end else if (bus_req_i.addr < INVALID_BASE) begin
			tgt  = board_pkg::SLV_RAM;
			offs = bus_req_i.addr - RAM_BASE;
		end
	end

	assign accept = (state_q == ST_IDLE) && (bus_req_i.op != board_pkg::OP_NONE) && !sys_rst_i;

	always_comb begin
		slv_req_o      = bus_req_i;
		slv_req_o.addr = offs;
	end

	assign devtbl_sel_o = accept && (tgt == board_pkg::SLV_DEVTBL);
	assign ram_sel_o    = accept && (tgt == board_pkg::SLV_RAM);

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
		end else if (accept) begin
			state_q <= ST_RSP;
		end else begin
			state_q <= ST_IDLE;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (accept) begin
			slave_q <= tgt;
		end
	end

	// the invalid device answers by itself with zero data
	always_comb begin
		bus_rsp_o = '0;
		if (state_q == ST_RSP) begin
			case (slave_q)
				board_pkg::SLV_DEVTBL: bus_rsp_o = devtbl_rsp_i;
				board_pkg::SLV_RAM:    bus_rsp_o = ram_rsp_i;
				default:               bus_rsp_o.rdy = 1'b1;
			endcase
		end
	end

	a_devtbl_rdy: assert property (@(posedge clk120mhz) disable iff (sys_rst_i)
		devtbl_rsp_i.rdy |-> $past(devtbl_sel_o));

	a_ram_rdy: assert property (@(posedge clk120mhz) disable iff (sys_rst_i)
		ram_rsp_i.rdy |-> $past(ram_sel_o));

	a_one_sel: assert property (@(posedge clk120mhz) !(devtbl_sel_o && ram_sel_o));

endmodule

//--- source/dev_table.sv
//******************************
// entries 2i and 2i+1 give id and map size of slave i
// word 32 is the reset control register, cleared by sys_rst
//******************************
`timescale 1ns/1ps

module dev_table #(
	parameter int RAM_WORDS = 256
) (
	input  logic                 clk120mhz,
	input  logic                 sys_rst_i,
	input  logic                 sel_i,
	input  board_pkg::bus_req_t  req_i,
	output board_pkg::bus_rsp_t  rsp_o,
	output board_pkg::rst_ctrl_t rst_ctrl_o
);

	// invalid device covers 4 KB
	localparam board_pkg::arch_word_t INVALID_MAPSZ = 32'd1024;

	board_pkg::rst_ctrl_t rst_ctrl_q;
	board_pkg::arch_word_t tbl_word;
	board_pkg::arch_word_t rd_data_q;
	logic                  rdy_q;

	function automatic board_pkg::arch_word_t slave_entry(board_pkg::slave_idx_t idx,
		logic size_sel);
		board_pkg::arch_word_t id;
		board_pkg::arch_word_t mapsz;
		case (idx)
			board_pkg::SLV_DEVTBL: begin
				id    = board_pkg::DEVTBL_ID;
				mapsz = board_pkg::arch_word_t'(board_pkg::DEVTBL_MAPSZ);
			end
			board_pkg::SLV_RAM: begin
				id    = board_pkg::RAM_ID;
				mapsz = board_pkg::arch_word_t'(RAM_WORDS);
			end
			default: begin
				id    = board_pkg::INVALID_ID;
				mapsz = INVALID_MAPSZ;
			end
		endcase
		return size_sel ? mapsz : id;
	endfunction

	always_comb begin
		tbl_word = '0;
		if (req_i.addr < board_pkg::word_addr_t'(2 * board_pkg::SLAVE_COUNT)) begin
			tbl_word = slave_entry(board_pkg::slave_idx_t'(req_i.addr >> 1), req_i.addr[0]);
		end else if (req_i.addr == board_pkg::RSTCTRL_OFFSET) begin
			tbl_word = {30'd0, rst_ctrl_q};
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rdy_q      <= 1'b0;
			rst_ctrl_q <= '0;
		end else begin
			rdy_q <= sel_i;
			// only byte lane 0 reaches the control bits
			if (sel_i && req_i.op == board_pkg::OP_WRITE &&
				req_i.addr == board_pkg::RSTCTRL_OFFSET && req_i.sel[0]) begin
				rst_ctrl_q <= board_pkg::rst_ctrl_t'(req_i.data[1:0]);
			end
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (sel_i && req_i.op == board_pkg::OP_READ) begin
			rd_data_q <= tbl_word;
		end
	end

	assign rsp_o.data = rd_data_q;
	assign rsp_o.rdy  = rdy_q;
	assign rst_ctrl_o = rst_ctrl_q;

endmodule

//--- source/ram_slave.sv
//******************************
// RAM_WORDS must be a power of two, at least 16
// contents are kept through every reset
//******************************
`timescale 1ns/1ps

module ram_slave #(
	parameter int RAM_WORDS = 256
) (
	input  logic                clk120mhz,
	input  logic                sel_i,
	input  board_pkg::bus_req_t req_i,
	output board_pkg::bus_rsp_t rsp_o
);

	localparam int IDX_BITS = $clog2(RAM_WORDS);
	localparam int LANES    = $bits(board_pkg::byte_sel_t);

	board_pkg::arch_word_t mem [RAM_WORDS];
	board_pkg::arch_word_t rd_data_q;
	logic                  rdy_q;
	logic [IDX_BITS-1:0]   idx;

	if (RAM_WORDS < 16 || (RAM_WORDS & (RAM_WORDS - 1)) != 0) begin : g_size_check
		$error("ram_slave needs a power of two of at least 16 words");
	end

	// the decoder already removed the RAM base
	assign idx = req_i.addr[IDX_BITS-1:0];

	always_ff @(posedge clk120mhz) begin
		rdy_q <= sel_i;
		if (sel_i && req_i.op == board_pkg::OP_WRITE) begin
			// disabled lanes keep their old byte
			for (int b = 0; b < LANES; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
				end
			end
		end else if (sel_i && req_i.op == board_pkg::OP_READ) begin
			rd_data_q <= mem[idx];
		end
	end

	assign rsp_o.data = rd_data_q;
	assign rsp_o.rdy  = rdy_q;

endmodule

//--- source/reset_clock_ctrl.sv
//******************************
// sys_rst holds 15 cycles after the last reload
// power-off is left only through rst_p
// ce60/ce30 are enables on clk120mhz, not clocks
//******************************
`timescale 1ns/1ps

module reset_clock_ctrl (
	input  logic                 clk120mhz,
	input  logic                 rst_p,
	input  board_pkg::rst_ctrl_t rst_ctrl_i,
	output logic                 sys_rst_o,
	output logic                 coldrst_o,
	output logic                 poweroff_o,
	output logic                 ce60_o,
	output logic                 ce30_o
);

	logic [board_pkg::RST_CNTR_BITS-1:0] rst_cntr_q;
	logic [1:0]                          clkdiv_q;
	logic                                cold_req;
	logic                                warm_req;
	logic                                off_req;
	logic                                cold_req_q;

	assign cold_req = rst_ctrl_i.rst1 && rst_ctrl_i.rst0;
	assign warm_req = rst_ctrl_i.rst1 && !rst_ctrl_i.rst0;
	assign off_req  = !rst_ctrl_i.rst1 && rst_ctrl_i.rst0;

	// hard reset and both software resets reload the stretch counter
	always_ff @(posedge clk120mhz) begin
		if (rst_p || cold_req || warm_req) begin
			rst_cntr_q <= '1;
		end else if (|rst_cntr_q) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// request stays up until sys_rst clears it, so pulse on its first cycle only
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			cold_req_q <= 1'b0;
			coldrst_o  <= 1'b0;
		end else begin
			cold_req_q <= cold_req;
			coldrst_o  <= cold_req && !cold_req_q;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			poweroff_o <= 1'b0;
		end else if (off_req) begin
			poweroff_o <= 1'b1;
		end
	end

	assign sys_rst_o = (|rst_cntr_q) || poweroff_o;

	// counting down keeps both enables in phase at zero
	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			clkdiv_q <= '0;
		end else begin
			clkdiv_q <= clkdiv_q - 1'b1;
		end
	end

	assign ce60_o = !clkdiv_q[0];
	assign ce30_o = (clkdiv_q == 2'b00);

	a_cold_pulse: assert property (@(posedge clk120mhz) disable iff (rst_p)
		coldrst_o |=> !coldrst_o);

endmodule

//--- source/board_ctrl.sv
//******************************
// master holds a request until rdy, one at a time
// device table at word 0, RAM at word 64, rest invalid
//******************************
`timescale 1ns/1ps

module board_ctrl #(
	parameter int RAM_WORDS = 256
) (
	input  logic                clk120mhz,
	input  logic                rst_p,
	input  board_pkg::bus_req_t bus_req_i,
	output board_pkg::bus_rsp_t bus_rsp_o,
	output logic                sys_rst_o,
	output logic                coldrst_o,
	output logic                poweroff_o,
	output logic                ce60_o,
	output logic                ce30_o
);

	board_pkg::bus_req_t  slv_req;
	board_pkg::bus_rsp_t  devtbl_rsp;
	board_pkg::bus_rsp_t  ram_rsp;
	board_pkg::rst_ctrl_t rst_ctrl;
	logic                 devtbl_sel;
	logic                 ram_sel;

	bus_decode #(.RAM_WORDS(RAM_WORDS)) i_bus_decode (
		.clk120mhz    (clk120mhz),
		.sys_rst_i    (sys_rst_o),
		.bus_req_i    (bus_req_i),
		.bus_rsp_o    (bus_rsp_o),
		.slv_req_o    (slv_req),
		.devtbl_sel_o (devtbl_sel),
		.ram_sel_o    (ram_sel),
		.devtbl_rsp_i (devtbl_rsp),
		.ram_rsp_i    (ram_rsp)
	);

	dev_table #(.RAM_WORDS(RAM_WORDS)) i_dev_table (
		.clk120mhz  (clk120mhz),
		.sys_rst_i  (sys_rst_o),
		.sel_i      (devtbl_sel),
		.req_i      (slv_req),
		.rsp_o      (devtbl_rsp),
		.rst_ctrl_o (rst_ctrl)
	);

	// stands in for the cached memory, no reset
	ram_slave #(.RAM_WORDS(RAM_WORDS)) i_ram_slave (
		.clk120mhz (clk120mhz),
		.sel_i     (ram_sel),
		.req_i     (slv_req),
		.rsp_o     (ram_rsp)
	);

	reset_clock_ctrl i_reset_clock_ctrl (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.rst_ctrl_i (rst_ctrl),
		.sys_rst_o  (sys_rst_o),
		.coldrst_o  (coldrst_o),
		.poweroff_o (poweroff_o),
		.ce60_o     (ce60_o),
		.ce30_o     (ce30_o)
	);

endmodule

//--- tests/board_ctrl_tb.sv
//******************************
// run from the project root so the golden file is found
// expects RAM_WORDS of 256 and the map in board_pkg
//******************************
`timescale 1ns/1ps

module board_ctrl_tb;

	localparam int          RAM_WORDS    = 256;
	localparam int          GOLD_WORDS   = 160;
	localparam int          FILL_WORDS   = 16;
	localparam logic [31:0] RAM_BASE     = 32'h100;
	localparam logic [31:0] RSTCTRL_ADDR = 32'h80;

	logic                  clk120mhz = 1'b0;
	logic                  rst_p;
	board_pkg::bus_req_t   bus_req;
	board_pkg::bus_rsp_t   bus_rsp;
	logic                  sys_rst;
	logic                  coldrst;
	logic                  poweroff;
	logic                  ce60;
	logic                  ce30;
	logic [31:0]           gold [GOLD_WORDS];
	board_pkg::arch_word_t shadow [FILL_WORDS];
	int                    gptr = 0;
	int                    err_count = 0;
	int                    test_base = 0;
	int                    tests_passed = 0;
	int                    tests_failed = 0;
	integer                seed = 49;

	board_ctrl #(.RAM_WORDS(RAM_WORDS)) i_dut (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.bus_req_i  (bus_req),
		.bus_rsp_o  (bus_rsp),
		.sys_rst_o  (sys_rst),
		.coldrst_o  (coldrst),
		.poweroff_o (poweroff),
		.ce60_o     (ce60),
		.ce30_o     (ce30)
	);

	always #10 clk120mhz = ~clk120mhz;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		err_count++;
	endtask

	task automatic check_word(input string name, input board_pkg::arch_word_t got,
		input board_pkg::arch_word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// enabled lanes take the new byte, the rest keep the old one
	function automatic board_pkg::arch_word_t merge_lanes(board_pkg::arch_word_t old_w,
		board_pkg::arch_word_t new_w, board_pkg::byte_sel_t sel);
		board_pkg::arch_word_t mask;
		for (int b = 0; b < 4; b++) begin
			mask[8*b +: 8] = {8{sel[b]}};
		end
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	task automatic bus_xfer(input board_pkg::bus_op_t op, input logic [31:0] addr,
		input board_pkg::arch_word_t wdata, input board_pkg::byte_sel_t sel,
		output board_pkg::arch_word_t rdata);
		int   n;
		logic got;
		@(negedge clk120mhz);
		// the previous reply lasts one cycle only
		check_bit("bus_rsp_o.rdy", bus_rsp.rdy, 1'b0);
		bus_req.op   = op;
		bus_req.addr = addr[31:2];
		bus_req.data = wdata;
		bus_req.sel  = sel;
		rdata = '0;
		n = 0;
		got = 1'b0;
		while (!got && n < 20) begin
			@(negedge clk120mhz);
			got = bus_rsp.rdy;
			n++;
		end
		if (got) begin
			rdata = bus_rsp.data;
			// accepted at the first edge, so rdy shows in the next cycle
			if (n != 1) begin
				report_failure($sformatf("rdy for access at %h came after %0d cycles, not 1",
					addr, n));
			end
		end else begin
			report_failure($sformatf("no rdy within 20 cycles for access at %h", addr));
		end
		bus_req = '0;
	endtask

	task automatic wait_sys_rst(input logic level, output int pulses);
		int   n;
		logic hit;
		n = 0;
		hit = 1'b0;
		pulses = 0;
		while (!hit && n < 50) begin
			@(negedge clk120mhz);
			pulses += coldrst;
			hit = (sys_rst == level);
			n++;
		end
		if (!hit) begin
			report_failure($sformatf("sys_rst_o did not reach %0d within 50 cycles", level));
		end
	endtask

	// a record with op 0 closes the group
	// RAM writes also update the shadow copy
	task automatic run_golden_group();
		board_pkg::bus_op_t    op;
		board_pkg::byte_sel_t  sel;
		board_pkg::arch_word_t wdata;
		board_pkg::arch_word_t exp;
		board_pkg::arch_word_t rdata;
		logic [31:0]           addr;
		logic                  done;
		int                    idx;
		done = 1'b0;
		while (!done) begin
			if (gptr + 5 > GOLD_WORDS || ^gold[gptr] === 1'bx) begin
				report_failure("golden file ends before the group marker");
				done = 1'b1;
			end else begin
				op    = gold[gptr][1:0];
				addr  = gold[gptr+1];
				wdata = gold[gptr+2];
				sel   = gold[gptr+3][3:0];
				exp   = gold[gptr+4];
				gptr += 5;
				if (op == board_pkg::OP_NONE) begin
					done = 1'b1;
				end else begin
					bus_xfer(op, addr, wdata, sel, rdata);
					if (op == board_pkg::OP_READ) begin
						check_word($sformatf("bus_rsp_o.data at %h", addr), rdata, exp);
					end else if (addr >= RAM_BASE && addr < RAM_BASE + 4*FILL_WORDS) begin
						idx = (addr - RAM_BASE) >> 2;
						shadow[idx] = merge_lanes(shadow[idx], wdata, sel);
					end
				end
			end
		end
	endtask

	task automatic ram_check_all();
		board_pkg::arch_word_t rdata;
		for (int i = 0; i < FILL_WORDS; i++) begin
			bus_xfer(board_pkg::OP_READ, RAM_BASE + 4*i, '0, 4'hf, rdata);
			check_word($sformatf("bus_rsp_o.data at %h", RAM_BASE + 4*i), rdata, shadow[i]);
		end
	endtask

	task automatic finish_test(input int num, input string title);
		if (err_count == test_base) begin
			$display("test %0d %s: pass", num, title);
			tests_passed++;
		end else begin
			$display("test %0d %s: fail, %0d errors", num, title, err_count - test_base);
			tests_failed++;
		end
		test_base = err_count;
	endtask

	initial begin
		board_pkg::arch_word_t rdata;
		board_pkg::arch_word_t data;
		board_pkg::byte_sel_t  sel;
		int                    pulses;
		int                    total;
		int                    cnt60;
		int                    cnt30;
		int                    stray;
		int                    n;
		logic                  hit;
		rst_p   = 1'b1;
		bus_req = '0;
		$readmemh("tests/board_ctrl_golden.hex", gold);
		repeat (10) @(negedge clk120mhz);
		rst_p = 1'b0;

		check_bit("bus_rsp_o.rdy", bus_rsp.rdy, 1'b0);
		check_bit("coldrst_o", coldrst, 1'b0);
		check_bit("poweroff_o", poweroff, 1'b0);
		check_bit("sys_rst_o", sys_rst, 1'b1);
		wait_sys_rst(1'b0, pulses);
		run_golden_group();
		finish_test(1, "device table readout");

		// seeded fill first with golden writes and random lane writes on top
		for (int i = 0; i < FILL_WORDS; i++) begin
			shadow[i] = $random(seed);
			bus_xfer(board_pkg::OP_WRITE, RAM_BASE + 4*i, shadow[i], 4'hf, rdata);
		end
		run_golden_group();
		for (int i = 4; i < FILL_WORDS; i++) begin
			data = $random(seed);
			sel  = board_pkg::byte_sel_t'($random(seed));
			bus_xfer(board_pkg::OP_WRITE, RAM_BASE + 4*i, data, sel, rdata);
			shadow[i] = merge_lanes(shadow[i], data, sel);
		end
		ram_check_all();
		finish_test(2, "RAM byte lanes");

		run_golden_group();
		finish_test(3, "invalid device");

		bus_xfer(board_pkg::OP_WRITE, RSTCTRL_ADDR, 32'd2, 4'h1, rdata);
		wait_sys_rst(1'b1, pulses);
		total = pulses;
		wait_sys_rst(1'b0, pulses);
		total += pulses;
		check_word("coldrst_o pulse count", board_pkg::arch_word_t'(total), 32'd0);
		bus_xfer(board_pkg::OP_READ, RSTCTRL_ADDR, '0, 4'hf, rdata);
		check_word("reset control register", rdata, 32'd0);
		ram_check_all();
		finish_test(4, "warm reset");

		bus_xfer(board_pkg::OP_WRITE, RSTCTRL_ADDR, 32'd3, 4'h1, rdata);
		wait_sys_rst(1'b1, pulses);
		total = pulses;
		wait_sys_rst(1'b0, pulses);
		total += pulses;
		check_word("coldrst_o pulse count", board_pkg::arch_word_t'(total), 32'd1);
		bus_xfer(board_pkg::OP_WRITE, RSTCTRL_ADDR, 32'd1, 4'h1, rdata);
		n = 0;
		hit = 1'b0;
		while (!hit && n < 20) begin
			@(negedge clk120mhz);
			hit = poweroff;
			n++;
		end
		if (!hit) begin
			report_failure("poweroff_o did not rise after the power-off write");
		end
		total = 0;
		repeat (40) begin
			@(negedge clk120mhz);
			total += sys_rst;
		end
		check_word("sys_rst_o high cycles", board_pkg::arch_word_t'(total), 32'd40);
		rst_p = 1'b1;
		repeat (2) @(negedge clk120mhz);
		rst_p = 1'b0;
		check_bit("poweroff_o", poweroff, 1'b0);
		check_bit("coldrst_o", coldrst, 1'b0);
		check_bit("bus_rsp_o.rdy", bus_rsp.rdy, 1'b0);
		finish_test(5, "cold reset and power-off");

		cnt60 = 0;
		cnt30 = 0;
		stray = 0;
		repeat (40) begin
			@(negedge clk120mhz);
			cnt60 += ce60;
			cnt30 += ce30;
			if (ce30 && !ce60) begin
				stray++;
			end
		end
		check_word("ce60_o count", board_pkg::arch_word_t'(cnt60), 32'd20);
		check_word("ce30_o count", board_pkg::arch_word_t'(cnt30), 32'd10);
		check_word("ce30_o without ce60_o", board_pkg::arch_word_t'(stray), 32'd0);
		wait_sys_rst(1'b0, pulses);
		finish_test(6, "clock enables");

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- tests/board_ctrl_golden.hex
// op (1 write, 2 read), byte address, write data, byte select, expected read data
// a record with op 0 closes a group, groups are device table, RAM, invalid device
2 00000000 00000000 f 00000007
2 00000004 00000000 f 00000040
2 00000008 00000000 f 00000001
2 0000000c 00000000 f 00000100
2 00000010 00000000 f 00000000
2 00000014 00000000 f 00000400
0 00000000 00000000 0 00000000
1 00000100 11223344 f 00000000
1 00000104 a5a5a5a5 f 00000000
1 00000108 deadbeef f 00000000
1 00000100 000000cc 1 00000000
1 00000104 5a00005a 9 00000000
1 00000108 0bad0000 c 00000000
1 00000108 0000f000 2 00000000
2 00000100 00000000 f 112233cc
2 00000104 00000000 f 5aa5a55a
2 00000108 00000000 f 0badf0ef
0 00000000 00000000 0 00000000
2 00000500 00000000 f 00000000
1 00000600 ffffffff f 00000000
2 00000600 00000000 f 00000000
0 00000000 00000000 0 00000000

//--- board_ctrl.f
source/board_pkg.sv
source/bus_decode.sv
source/dev_table.sv
source/ram_slave.sv
source/reset_clock_ctrl.sv
source/board_ctrl.sv
tests/board_ctrl_tb.sv
